// ==== Makefile ====
# Verilator build and run for the RV32I pipeline testbench

TOP       ?= tb_rv_core
FLIST     ?= flist.f
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= Test completed successfully

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: TOP FLIST LOG OBJ_DIR VERILATOR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation did not pass, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== alu.sv ====
`timescale 1ns/1ps

module alu (
  input  rv_pkg::alu_op_e op_i,
  input  rv_pkg::word_t   a_i,
  input  rv_pkg::word_t   b_i,
  output rv_pkg::word_t   result_o
);
  import rv_pkg::*;

  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;

  // shift amount from the low bits only
  assign shamt = b_i[4:0];

  // compares
  assign lt_signed   = $signed(a_i) < $signed(b_i);
  assign lt_unsigned = a_i < b_i;

  always_comb begin
    case (op_i)
      ALU_ADD:    result_o = a_i + b_i;
      ALU_SUB:    result_o = a_i - b_i;
      ALU_SLL:    result_o = a_i << shamt;
      ALU_SLT:    result_o = {31'b0, lt_signed};
      ALU_SLTU:   result_o = {31'b0, lt_unsigned};
      ALU_XOR:    result_o = a_i ^ b_i;
      ALU_SRL:    result_o = a_i >> shamt;
      // arithmetic shift keeps the sign bit
      ALU_SRA:    result_o = $unsigned($signed(a_i) >>> shamt);
      ALU_OR:     result_o = a_i | b_i;
      ALU_AND:    result_o = a_i & b_i;
      ALU_PASS_B: result_o = b_i;
      default:    result_o = '0;
    endcase
  end

endmodule

// ==== decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage (
  input  logic              clk,
  input  logic              arst_n_i,
  input  rv_pkg::word_t     inst_id_i,
  // register file read
  output rv_pkg::reg_addr_t rs1_o,
  output rv_pkg::reg_addr_t rs2_o,
  input  rv_pkg::word_t     rdata1_i,
  input  rv_pkg::word_t     rdata2_i,
  // id/ex register
  output rv_pkg::reg_addr_t rs1_ex_o,
  output rv_pkg::reg_addr_t rs2_ex_o,
  output rv_pkg::reg_addr_t rd_ex_o,
  output rv_pkg::word_t     rdata1_ex_o,
  output rv_pkg::word_t     rdata2_ex_o,
  output rv_pkg::word_t     imm_ex_o,
  output rv_pkg::alu_op_e   alu_op_ex_o,
  output logic              alu_src_ex_o,
  output logic              lui_ex_o,
  output logic              reg_write_ex_o,
  output logic              mem_write_ex_o
);
  import rv_pkg::*;

  opcode_e    opcode;
  logic [2:0] funct3;
  logic       funct7_5;
  reg_addr_t  rd;
  word_t      imm_i, imm_s, imm_u, imm;
  alu_op_e    alu_op_f3, alu_op;
  logic       alu_src, lui, reg_write, mem_write;

  // instruction fields
  assign opcode   = opcode_e'(inst_id_i[6:0]);
  assign rd       = inst_id_i[11:7];
  assign funct3   = inst_id_i[14:12];
  assign rs1_o    = inst_id_i[19:15];
  assign rs2_o    = inst_id_i[24:20];
  assign funct7_5 = inst_id_i[30];

  // immediate formats
  assign imm_i = {{20{inst_id_i[31]}}, inst_id_i[31:20]};
  assign imm_s = {{20{inst_id_i[31]}}, inst_id_i[31:25], inst_id_i[11:7]};
  assign imm_u = {inst_id_i[31:12], 12'b0};

  // alu op from funct3, sub only exists for register-register
  always_comb begin
    case (funct3)
      F3_ADD_SUB: alu_op_f3 = (opcode == OPC_OP && funct7_5) ? ALU_SUB : ALU_ADD;
      F3_SLL:     alu_op_f3 = ALU_SLL;
      F3_SLT:     alu_op_f3 = ALU_SLT;
      F3_SLTU:    alu_op_f3 = ALU_SLTU;
      F3_XOR:     alu_op_f3 = ALU_XOR;
      F3_SRL_SRA: alu_op_f3 = funct7_5 ? ALU_SRA : ALU_SRL;
      F3_OR:      alu_op_f3 = ALU_OR;
      F3_AND:     alu_op_f3 = ALU_AND;
      default:    alu_op_f3 = ALU_ADD;
    endcase
  end

  // ==================================================
  //   control decode
  // ==================================================

  always_comb begin
    alu_op    = alu_op_f3;
    imm       = imm_i;
    alu_src   = 1'b0;
    lui       = 1'b0;
    reg_write = 1'b0;
    mem_write = 1'b0;
    case (opcode)
      OPC_OP: begin
        reg_write = 1'b1;
      end
      OPC_OP_IMM: begin
        alu_src   = 1'b1;
        reg_write = 1'b1;
      end
      OPC_LUI: begin
        imm       = imm_u;
        alu_op    = ALU_PASS_B;
        alu_src   = 1'b1;
        lui       = 1'b1;
        reg_write = 1'b1;
      end
      OPC_STORE: begin
        // address is rs1 + s-immediate, only word stores are accepted
        imm       = imm_s;
        alu_op    = ALU_ADD;
        alu_src   = 1'b1;
        mem_write = (funct3 == F3_SW);
      end
      default: begin
        alu_op = ALU_ADD;
      end
    endcase
  end

  // ==================================================
  //   id/ex register
  // ==================================================

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      alu_op_ex_o    <= ALU_ADD;
      alu_src_ex_o   <= 1'b0;
      lui_ex_o       <= 1'b0;
      reg_write_ex_o <= 1'b0;
      mem_write_ex_o <= 1'b0;
    end else begin
      alu_op_ex_o    <= alu_op;
      alu_src_ex_o   <= alu_src;
      lui_ex_o       <= lui;
      reg_write_ex_o <= reg_write;
      mem_write_ex_o <= mem_write;
    end
  end

  always_ff @(posedge clk) begin
    rs1_ex_o    <= rs1_o;
    rs2_ex_o    <= rs2_o;
    rd_ex_o     <= rd;
    rdata1_ex_o <= rdata1_i;
    rdata2_ex_o <= rdata2_i;
    imm_ex_o    <= imm;
  end

endmodule

// ==== execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage (
  input  logic              clk,
  input  logic              arst_n_i,
  // id/ex register
  input  rv_pkg::reg_addr_t rs1_ex_i,
  input  rv_pkg::reg_addr_t rs2_ex_i,
  input  rv_pkg::reg_addr_t rd_ex_i,
  input  rv_pkg::word_t     rdata1_ex_i,
  input  rv_pkg::word_t     rdata2_ex_i,
  input  rv_pkg::word_t     imm_ex_i,
  input  rv_pkg::alu_op_e   alu_op_ex_i,
  input  logic              alu_src_ex_i,
  input  logic              lui_ex_i,
  input  logic              reg_write_ex_i,
  input  logic              mem_write_ex_i,
  // write-back forwarding source
  input  rv_pkg::reg_addr_t rd_wb_i,
  input  logic              reg_write_wb_i,
  input  rv_pkg::word_t     result_wb_i,
  // ex/mem register
  output rv_pkg::word_t     alu_result_mem_o,
  output rv_pkg::word_t     store_data_mem_o,
  output rv_pkg::reg_addr_t rd_mem_o,
  output logic              reg_write_mem_o,
  output logic              mem_write_mem_o
);
  import rv_pkg::*;

  fwd_sel_e fwd_a, fwd_b;
  word_t    src_a, src_b;
  word_t    op_a, op_b;
  word_t    alu_result;

  // mem stage wins over wb, x0 is never forwarded
  function automatic fwd_sel_e fwd_select(input reg_addr_t src);
    if (reg_write_mem_o && rd_mem_o != 5'd0 && rd_mem_o == src) begin
      return FWD_MEM;
    end
    if (reg_write_wb_i && rd_wb_i != 5'd0 && rd_wb_i == src) begin
      return FWD_WB;
    end
    return FWD_NONE;
  endfunction

  function automatic word_t fwd_value(input fwd_sel_e sel, input word_t reg_val);
    case (sel)
      FWD_MEM: return alu_result_mem_o;
      FWD_WB:  return result_wb_i;
      default: return reg_val;
    endcase
  endfunction

  // ==================================================
  //   operand selection
  // ==================================================

  // selects follow the ex/mem and mem/wb registers as well as id/ex
  always_comb begin
    fwd_a = fwd_select(rs1_ex_i);
    fwd_b = fwd_select(rs2_ex_i);
    src_a = fwd_value(fwd_a, rdata1_ex_i);
    src_b = fwd_value(fwd_b, rdata2_ex_i);
  end

  // lui adds the upper immediate to zero
  assign op_a = lui_ex_i ? '0 : src_a;
  assign op_b = alu_src_ex_i ? imm_ex_i : src_b;

  alu u_alu (
    .op_i    (alu_op_ex_i),
    .a_i     (op_a),
    .b_i     (op_b),
    .result_o(alu_result)
  );

  // ==================================================
  //   ex/mem register
  // ==================================================

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      reg_write_mem_o <= 1'b0;
      mem_write_mem_o <= 1'b0;
    end else begin
      reg_write_mem_o <= reg_write_ex_i;
      mem_write_mem_o <= mem_write_ex_i;
    end
  end

  // store data is the forwarded rs2
  always_ff @(posedge clk) begin
    alu_result_mem_o <= alu_result;
    store_data_mem_o <= src_b;
    rd_mem_o         <= rd_ex_i;
  end

endmodule

// ==== fetch_stage.sv ====
`timescale 1ns/1ps

module fetch_stage #(
  parameter rv_pkg::word_t RESET_PC = 32'h0000_0000
) (
  input  logic          clk,
  input  logic          arst_n_i,
  output rv_pkg::word_t imem_addr_o,
  input  rv_pkg::word_t imem_data_i,
  output rv_pkg::word_t pc_id_o,
  output rv_pkg::word_t inst_id_o
);
  import rv_pkg::*;

  word_t pc;

  // memory returns the word for this address in the same cycle
  assign imem_addr_o = pc;

  // no branches, so the pc only ever steps forward
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pc <= RESET_PC;
    end else begin
      pc <= pc + 32'd4;
    end
  end

  // ==================================================
  //   if/id register
  // ==================================================

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      inst_id_o <= NOP_INST;
    end else begin
      inst_id_o <= imem_data_i;
    end
  end

  always_ff @(posedge clk) begin
    pc_id_o <= pc;
  end

endmodule

// ==== flist.f ====
+incdir+.
rv_pkg.sv
alu.sv
fetch_stage.sv
decode_stage.sv
reg_file.sv
execute_stage.sv
memory_stage.sv
rv_core_top.sv
tb_rv_core.sv

// ==== memory_stage.sv ====
`timescale 1ns/1ps

module memory_stage (
  input  logic              clk,
  input  logic              arst_n_i,
  // ex/mem register
  input  rv_pkg::word_t     alu_result_i,
  input  rv_pkg::word_t     store_data_i,
  input  rv_pkg::reg_addr_t rd_i,
  input  logic              reg_write_i,
  input  logic              mem_write_i,
  // data memory bus
  output logic              dmem_we_o,
  output rv_pkg::word_t     dmem_addr_o,
  output rv_pkg::word_t     dmem_wdata_o,
  // mem/wb register
  output rv_pkg::reg_addr_t rd_wb_o,
  output logic              reg_write_wb_o,
  output rv_pkg::word_t     result_wb_o
);

  // single-cycle store strobe, the memory never stalls us
  assign dmem_we_o    = mem_write_i;
  assign dmem_addr_o  = alu_result_i;
  assign dmem_wdata_o = store_data_i;

  // ==================================================
  //   mem/wb register
  // ==================================================

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      reg_write_wb_o <= 1'b0;
    end else begin
      reg_write_wb_o <= reg_write_i;
    end
  end

  // no loads, so the alu result is the write-back value
  always_ff @(posedge clk) begin
    rd_wb_o     <= rd_i;
    result_wb_o <= alu_result_i;
  end

endmodule

// ==== reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
  input  logic              clk,
  input  logic              arst_n_i,
  // read ports, used by decode
  input  rv_pkg::reg_addr_t raddr1_i,
  input  rv_pkg::reg_addr_t raddr2_i,
  output rv_pkg::word_t     rdata1_o,
  output rv_pkg::word_t     rdata2_o,
  // write port from write-back
  input  logic              we_i,
  input  rv_pkg::reg_addr_t waddr_i,
  input  rv_pkg::word_t     wdata_i
);
  import rv_pkg::*;

  // x0 has no storage
  word_t regs [1:31];
  logic  wr_en;

  assign wr_en = we_i && (waddr_i != 5'd0);

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  // write-through so decode sees a value written in the same cycle
  assign rdata1_o = (raddr1_i == 5'd0)                 ? '0      :
                    (wr_en && raddr1_i == waddr_i)     ? wdata_i :
                                                         regs[raddr1_i];
  assign rdata2_o = (raddr2_i == 5'd0)                 ? '0      :
                    (wr_en && raddr2_i == waddr_i)     ? wdata_i :
                                                         regs[raddr2_i];

endmodule

// ==== rv_core_top.sv ====
`timescale 1ns/1ps

module rv_core_top #(
  parameter rv_pkg::word_t RESET_PC = 32'h0000_0000
) (
  input  logic          clk,
  input  logic          arst_n_i,
  // instruction memory bus
  output rv_pkg::word_t imem_addr_o,
  input  rv_pkg::word_t imem_data_i,
  // data memory bus, stores only
  output logic          dmem_we_o,
  output rv_pkg::word_t dmem_addr_o,
  output rv_pkg::word_t dmem_wdata_o
);
  import rv_pkg::*;

  // decode side
  word_t     inst_id;
  reg_addr_t rs1, rs2;
  word_t     rdata1, rdata2;

  // id/ex
  reg_addr_t rs1_ex, rs2_ex, rd_ex;
  word_t     rdata1_ex, rdata2_ex, imm_ex;
  alu_op_e   alu_op_ex;
  logic      alu_src_ex, lui_ex, reg_write_ex, mem_write_ex;

  // ex/mem
  word_t     alu_result_mem, store_data_mem;
  reg_addr_t rd_mem;
  logic      reg_write_mem, mem_write_mem;

  // mem/wb
  reg_addr_t rd_wb;
  logic      reg_write_wb;
  word_t     result_wb;

  // ==================================================
  //   fetch
  // ==================================================

  fetch_stage #(
    .RESET_PC(RESET_PC)
  ) u_fetch (
    .clk        (clk),
    .arst_n_i   (arst_n_i),
    .imem_addr_o(imem_addr_o),
    .imem_data_i(imem_data_i),
    .pc_id_o    (),
    .inst_id_o  (inst_id)
  );

  // ==================================================
  //   decode and register file
  // ==================================================

  decode_stage u_decode (
    .clk           (clk),
    .arst_n_i      (arst_n_i),
    .inst_id_i     (inst_id),
    .rs1_o         (rs1),
    .rs2_o         (rs2),
    .rdata1_i      (rdata1),
    .rdata2_i      (rdata2),
    .rs1_ex_o      (rs1_ex),
    .rs2_ex_o      (rs2_ex),
    .rd_ex_o       (rd_ex),
    .rdata1_ex_o   (rdata1_ex),
    .rdata2_ex_o   (rdata2_ex),
    .imm_ex_o      (imm_ex),
    .alu_op_ex_o   (alu_op_ex),
    .alu_src_ex_o  (alu_src_ex),
    .lui_ex_o      (lui_ex),
    .reg_write_ex_o(reg_write_ex),
    .mem_write_ex_o(mem_write_ex)
  );

  // written from write-back
  reg_file u_reg_file (
    .clk     (clk),
    .arst_n_i(arst_n_i),
    .raddr1_i(rs1),
    .raddr2_i(rs2),
    .rdata1_o(rdata1),
    .rdata2_o(rdata2),
    .we_i    (reg_write_wb),
    .waddr_i (rd_wb),
    .wdata_i (result_wb)
  );

  // ==================================================
  //   execute
  // ==================================================

  execute_stage u_execute (
    .clk             (clk),
    .arst_n_i        (arst_n_i),
    .rs1_ex_i        (rs1_ex),
    .rs2_ex_i        (rs2_ex),
    .rd_ex_i         (rd_ex),
    .rdata1_ex_i     (rdata1_ex),
    .rdata2_ex_i     (rdata2_ex),
    .imm_ex_i        (imm_ex),
    .alu_op_ex_i     (alu_op_ex),
    .alu_src_ex_i    (alu_src_ex),
    .lui_ex_i        (lui_ex),
    .reg_write_ex_i  (reg_write_ex),
    .mem_write_ex_i  (mem_write_ex),
    .rd_wb_i         (rd_wb),
    .reg_write_wb_i  (reg_write_wb),
    .result_wb_i     (result_wb),
    .alu_result_mem_o(alu_result_mem),
    .store_data_mem_o(store_data_mem),
    .rd_mem_o        (rd_mem),
    .reg_write_mem_o (reg_write_mem),
    .mem_write_mem_o (mem_write_mem)
  );

  // ==================================================
  //   memory
  // ==================================================

  memory_stage u_memory (
    .clk           (clk),
    .arst_n_i      (arst_n_i),
    .alu_result_i  (alu_result_mem),
    .store_data_i  (store_data_mem),
    .rd_i          (rd_mem),
    .reg_write_i   (reg_write_mem),
    .mem_write_i   (mem_write_mem),
    .dmem_we_o     (dmem_we_o),
    .dmem_addr_o   (dmem_addr_o),
    .dmem_wdata_o  (dmem_wdata_o),
    .rd_wb_o       (rd_wb),
    .reg_write_wb_o(reg_write_wb),
    .result_wb_o   (result_wb)
  );

endmodule

// ==== rv_pkg.sv ====
package rv_pkg;

  // basic data types
  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;

  // ==================================================
  //   major opcodes
  // ==================================================

  // anything outside this set decodes as a no-op
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_STORE  = 7'b0100011
  } opcode_e;

  // ==================================================
  //   alu and forwarding selects
  // ==================================================

  typedef enum logic [3:0] {
    ALU_ADD    = 4'd0,
    ALU_SUB    = 4'd1,
    ALU_SLL    = 4'd2,
    ALU_SLT    = 4'd3,
    ALU_SLTU   = 4'd4,
    ALU_XOR    = 4'd5,
    ALU_SRL    = 4'd6,
    ALU_SRA    = 4'd7,
    ALU_OR     = 4'd8,
    ALU_AND    = 4'd9,
    ALU_PASS_B = 4'd10
  } alu_op_e;

  // operand source in execute
  typedef enum logic [1:0] {
    FWD_NONE = 2'b00,
    FWD_MEM  = 2'b01,
    FWD_WB   = 2'b10
  } fwd_sel_e;

  // addi x0, x0, 0
  localparam word_t NOP_INST = 32'h0000_0013;

  // funct3 encodings
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SRL_SRA = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;
  localparam logic [2:0] F3_SW      = 3'b010;

endpackage

// ==== tb_cases.svh ====
`ifndef TB_CASES_SVH
`define TB_CASES_SVH

// op on x1 and x2 into x3, result stored at 0x40
task automatic rr_case(input string name, input logic [6:0] f7, input logic [2:0] f3,
                       input word_t a, input word_t b, input word_t result);
  new_case(name);
  load_const(5'd1, a);
  load_const(5'd2, b);
  push_inst(r_type(f7, 5'd2, 5'd1, f3, 5'd3));
  push_inst(s_type(12'h040, 5'd3, 5'd0));
  expect_store(32'h0000_0040, result);
endtask

// immediate op on x1 into x3, result stored at 0x44
task automatic imm_case(input string name, input logic [2:0] f3, input logic [11:0] imm,
                        input word_t a, input word_t result);
  new_case(name);
  load_const(5'd1, a);
  push_inst(i_type(imm, 5'd1, f3, 5'd3, OPC_OP_IMM));
  push_inst(s_type(12'h044, 5'd3, 5'd0));
  expect_store(32'h0000_0044, result);
endtask

task automatic build_cases();
  word_t       a, b, r, x1, x2;
  logic [11:0] imm;
  logic [4:0]  sh;

  // ==================================================
  //   register-register
  // ==================================================

  // a negative, b positive
  a  = 32'h9abc_def1;
  b  = 32'h1234_5673;
  sh = b[4:0];
  rr_case("add", 7'h00, F3_ADD_SUB, a, b, a + b);
  rr_case("sub", 7'h20, F3_ADD_SUB, a, b, a + ~b + 32'd1);
  rr_case("sll", 7'h00, F3_SLL, a, b, a << sh);
  rr_case("slt", 7'h00, F3_SLT, a, b, {31'b0, (a[31] != b[31]) ? a[31] : (a < b)});
  rr_case("sltu", 7'h00, F3_SLTU, a, b, {31'b0, a < b});
  rr_case("xor", 7'h00, F3_XOR, a, b, a ^ b);
  rr_case("srl", 7'h00, F3_SRL_SRA, a, b, a >> sh);
  rr_case("sra", 7'h20, F3_SRL_SRA, a, b,
          (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'h0));
  rr_case("or", 7'h00, F3_OR, a, b, a | b);
  rr_case("and", 7'h00, F3_AND, a, b, a & b);

  // ==================================================
  //   register-immediate, immediates from the lfsr
  // ==================================================

  a   = 32'hc0de_1357;
  r   = lfsr_bits(12);
  imm = r[11:0];
  imm_case("addi", F3_ADD_SUB, imm, a, a + sext12(imm));
  r   = lfsr_bits(12);
  imm = r[11:0];
  imm_case("xori", F3_XOR, imm, a, a ^ sext12(imm));
  r   = lfsr_bits(12);
  imm = r[11:0];
  imm_case("ori", F3_OR, imm, a, a | sext12(imm));
  r   = lfsr_bits(12);
  imm = r[11:0];
  imm_case("andi", F3_AND, imm, a, a & sext12(imm));
  r   = lfsr_bits(12);
  imm = r[11:0];
  x1  = sext12(imm);
  imm_case("slti", F3_SLT, imm, a, {31'b0, (a[31] != x1[31]) ? a[31] : (a < x1)});
  r   = lfsr_bits(5);
  sh  = r[4:0];
  imm_case("slli", F3_SLL, {7'h00, sh}, a, a << sh);
  imm_case("srli", F3_SRL_SRA, {7'h00, sh}, a, a >> sh);
  imm_case("srai", F3_SRL_SRA, {7'h20, sh}, a,
           (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'h0));

  // ==================================================
  //   forwarding, x0 and store addressing
  // ==================================================

  // x1 read at distance 1, then x2 at 2 and x1 at 3 for the add
  new_case("fwd_dist");
  r   = lfsr_bits(12);
  imm = r[11:0];
  x1  = sext12(imm);
  push_inst(i_type(imm, 5'd0, F3_ADD_SUB, 5'd1, OPC_OP_IMM));
  r   = lfsr_bits(12);
  imm = r[11:0];
  x2  = x1 + sext12(imm);
  push_inst(i_type(imm, 5'd1, F3_ADD_SUB, 5'd2, OPC_OP_IMM));
  push_inst(NOP_INST);
  push_inst(r_type(7'h00, 5'd2, 5'd1, F3_ADD_SUB, 5'd3));
  push_inst(s_type(12'h010, 5'd3, 5'd0));
  push_inst(s_type(12'h014, 5'd2, 5'd0));
  push_inst(s_type(12'h018, 5'd1, 5'd0));
  expect_store(32'h0000_0010, x1 + x2);
  expect_store(32'h0000_0014, x2);
  expect_store(32'h0000_0018, x1);

  // x0 written one and two slots before it is read
  new_case("x0_write");
  push_inst(i_type(12'h123, 5'd0, F3_ADD_SUB, 5'd0, OPC_OP_IMM));
  push_inst(r_type(7'h00, 5'd0, 5'd0, F3_ADD_SUB, 5'd4));
  push_inst(s_type(12'h020, 5'd0, 5'd0));
  push_inst(s_type(12'h024, 5'd4, 5'd0));
  expect_store(32'h0000_0020, 32'h0);
  expect_store(32'h0000_0024, 32'h0);

  // unknown opcode aimed at x6 and a byte store, neither may act
  new_case("st_addr");
  load_const(5'd5, 32'h0000_2000);
  push_inst(i_type(12'h055, 5'd0, F3_ADD_SUB, 5'd6, OPC_OP_IMM));
  push_inst({12'hfff, 5'd0, 3'b000, 5'd6, 7'b1111111});
  push_inst({7'h00, 5'd6, 5'd5, 3'b000, 5'd0, OPC_STORE});
  r   = lfsr_bits(12);
  imm = r[11:0];
  push_inst(s_type(imm, 5'd6, 5'd5));
  push_inst(s_type(12'hff8, 5'd6, 5'd5));
  expect_store(32'h0000_2000 + sext12(imm), 32'h0000_0055);
  expect_store(32'h0000_1ff8, 32'h0000_0055);
endtask

`endif

// ==== tb_rv_core.sv ====
`timescale 1ns/1ps

module tb_rv_core;
  import rv_pkg::*;

  localparam int          HALF_PERIOD   = 50;
  localparam int          RESET_CYCLES  = 3;
  localparam int          MAX_CASES     = 24;
  localparam int          PROG_LEN      = 8;
  localparam int          MAX_STORES    = 3;
  localparam int          STORE_TIMEOUT = 20;
  localparam int          DRAIN_TIMEOUT = 20;
  localparam logic [15:0] LFSR_SEED     = 16'd35;

  logic  clk;
  logic  arst_n;
  word_t imem_addr;
  word_t imem_data;
  logic  dmem_we;
  word_t dmem_addr;
  word_t dmem_wdata;

  // test table, one row per test
  string case_name [MAX_CASES];
  word_t case_prog [MAX_CASES][PROG_LEN];
  int    case_len  [MAX_CASES];
  int    case_nst  [MAX_CASES];
  word_t case_addr [MAX_CASES][MAX_STORES];
  word_t case_data [MAX_CASES][MAX_STORES];

  int          n_cases;
  int          cur_case;
  int          err_count;
  int          n_pass;
  logic [15:0] lfsr_state;

  // stores seen on the data bus since the last reset
  word_t st_addr_q [$];
  word_t st_data_q [$];

  rv_core_top #(
    .RESET_PC(32'h0000_0000)
  ) UUT (
    .clk         (clk),
    .arst_n_i    (arst_n),
    .imem_addr_o (imem_addr),
    .imem_data_i (imem_data),
    .dmem_we_o   (dmem_we),
    .dmem_addr_o (dmem_addr),
    .dmem_wdata_o(dmem_wdata)
  );

  always begin
    #(HALF_PERIOD) clk = ~clk;
  end

  // ==================================================
  //   memory models
  // ==================================================

  function automatic word_t fetch_word(input word_t addr);
    int idx;
    idx = int'(addr >> 2);
    if (idx < case_len[cur_case]) begin
      return case_prog[cur_case][idx];
    end
    return NOP_INST;
  endfunction

  // instruction word for the pc shown after each edge
  always @(posedge clk) begin
    #1;
    imem_data = fetch_word(imem_addr);
  end

  // bus outputs settle after the rising edge
  always @(negedge clk) begin
    if (arst_n && dmem_we) begin
      st_addr_q.push_back(dmem_addr);
      st_data_q.push_back(dmem_wdata);
    end
  end

  // ==================================================
  //   encoders and table helpers
  // ==================================================

  // galois lfsr, one step per bit taken
  function automatic word_t lfsr_bits(input int n);
    word_t r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], lfsr_state[0]};
      lfsr_state = {1'b0, lfsr_state[15:1]} ^ (lfsr_state[0] ? 16'hb400 : 16'h0000);
    end
    return r;
  endfunction

  function automatic word_t sext12(input logic [11:0] v);
    return {{20{v[11]}}, v};
  endfunction

  function automatic word_t r_type(input logic [6:0] f7, input reg_addr_t rs2,
                                   input reg_addr_t rs1, input logic [2:0] f3,
                                   input reg_addr_t rd);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
  endfunction

  function automatic word_t i_type(input logic [11:0] imm, input reg_addr_t rs1,
                                   input logic [2:0] f3, input reg_addr_t rd,
                                   input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic word_t s_type(input logic [11:0] imm, input reg_addr_t rs2,
                                   input reg_addr_t rs1);
    return {imm[11:5], rs2, rs1, F3_SW, imm[4:0], OPC_STORE};
  endfunction

  function automatic word_t u_type(input logic [19:0] imm, input reg_addr_t rd);
    return {imm, rd, OPC_LUI};
  endfunction

  task automatic new_case(input string name);
    case_name[n_cases] = name;
    case_len[n_cases]  = 0;
    case_nst[n_cases]  = 0;
    n_cases++;
  endtask

  task automatic push_inst(input word_t inst);
    case_prog[n_cases - 1][case_len[n_cases - 1]] = inst;
    case_len[n_cases - 1]++;
  endtask

  task automatic expect_store(input word_t addr, input word_t data);
    case_addr[n_cases - 1][case_nst[n_cases - 1]] = addr;
    case_data[n_cases - 1][case_nst[n_cases - 1]] = data;
    case_nst[n_cases - 1]++;
  endtask

  // lui then addi, upper part rounded for the sign of the low 12 bits
  task automatic load_const(input reg_addr_t rd, input word_t value);
    word_t rounded;
    rounded = value + 32'h0000_0800;
    push_inst(u_type(rounded[31:12], rd));
    push_inst(i_type(value[11:0], rd, F3_ADD_SUB, rd, OPC_OP_IMM));
  endtask

`include "tb_cases.svh"

  // ==================================================
  //   checks and test loop
  // ==================================================

  task automatic check_addr(input string name, input word_t exp, input word_t act);
    if (act !== exp) begin
      $display("CHECK FAILED %s store address: expected %h, actual %h", name, exp, act);
      err_count++;
    end
  endtask

  task automatic check_data(input string name, input word_t exp, input word_t act);
    if (act !== exp) begin
      $display("CHECK FAILED %s store data: expected %h, actual %h", name, exp, act);
      err_count++;
    end
  endtask

  task automatic reset_core(input int c);
    @(posedge clk);
    #1;
    arst_n   = 1'b0;
    cur_case = c;
    st_addr_q.delete();
    st_data_q.delete();
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    arst_n = 1'b1;
  endtask

  task automatic run_case(input int c);
    int waited;
    int errs_before;
    errs_before = err_count;
    reset_core(c);
    for (int s = 0; s < case_nst[c]; s++) begin
      waited = 0;
      while (st_addr_q.size() <= s && waited < STORE_TIMEOUT) begin
        @(posedge clk);
        waited++;
      end
      if (st_addr_q.size() <= s) begin
        $display("%s: no store %0d seen within %0d cycles", case_name[c], s, STORE_TIMEOUT);
        err_count++;
        break;
      end
    end
    // last instruction has to leave the pipeline before stores are counted
    waited = 0;
    while (int'(imem_addr >> 2) < case_len[c] + 4 && waited < DRAIN_TIMEOUT) begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (int'(imem_addr >> 2) < case_len[c] + 4) begin
      $display("%s: program did not run to its end in time", case_name[c]);
      err_count++;
    end else if (st_addr_q.size() != case_nst[c]) begin
      $display("%s: expected %0d stores but saw %0d", case_name[c], case_nst[c],
               st_addr_q.size());
      err_count++;
    end else begin
      for (int s = 0; s < case_nst[c]; s++) begin
        check_addr($sformatf("%s[%0d]", case_name[c], s), case_addr[c][s], st_addr_q[s]);
        check_data($sformatf("%s[%0d]", case_name[c], s), case_data[c][s], st_data_q[s]);
      end
    end
    if (err_count == errs_before) begin
      n_pass++;
      $display("%s: ok", case_name[c]);
    end else begin
      $display("%s: %0d errors", case_name[c], err_count - errs_before);
    end
  endtask

  initial begin
    clk        = 1'b0;
    arst_n     = 1'b0;
    imem_data  = NOP_INST;
    lfsr_state = LFSR_SEED;
    n_cases    = 0;
    cur_case   = 0;
    err_count  = 0;
    n_pass     = 0;
    build_cases();
    for (int c = 0; c < n_cases; c++) begin
      run_case(c);
    end
    $display("%0d tests, %0d passed, %0d failed, %0d errors", n_cases, n_pass,
             n_cases - n_pass, err_count);
    if (err_count == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule
